// File: hdl/conv_csr_pkg.sv
package conv_csr_pkg;

	// --------------------
	// Bus and index widths
	// --------------------

	// Data width is fixed, the control word layout depends on it
	localparam int csr_data_w = 32;
	// One strobe per byte lane
	localparam int csr_strb_w = csr_data_w / 8;
	// Word index, 16 slots of which 10 are mapped
	localparam int csr_index_w = 4;
	// Byte offset bits below the word index
	localparam int addr_lsb = 2;
	localparam int csr_num_words = 10;

	// --------------------
	// Register word map
	// --------------------

	localparam logic [csr_index_w-1:0] idx_ctrl           = 4'd0;
	localparam logic [csr_index_w-1:0] idx_kernel_base    = 4'd1;
	localparam logic [csr_index_w-1:0] idx_feature_base   = 4'd2;
	localparam logic [csr_index_w-1:0] idx_feature_width  = 4'd3;
	localparam logic [csr_index_w-1:0] idx_feature_height = 4'd4;
	localparam logic [csr_index_w-1:0] idx_feature_chin   = 4'd5;
	localparam logic [csr_index_w-1:0] idx_feature_chout  = 4'd6;
	localparam logic [csr_index_w-1:0] idx_output_base    = 4'd7;
	localparam logic [csr_index_w-1:0] idx_output_width   = 4'd8;
	localparam logic [csr_index_w-1:0] idx_output_height  = 4'd9;

	// --------------------
	// Word 0 layout
	// --------------------

	// Listed from bit 31 down to bit 0
	typedef struct packed {
		logic [7:0] kernel_size;
		logic [7:0] stride;
		logic [7:0] padding;
		logic       has_bias;
		logic       has_relu;
		logic       conv_mode;
		// Bit 4, always reads zero
		logic       reserved;
		// Bits 3 to 1 are read-only status
		logic       running;
		logic       compute_done;
		logic       exception;
		// Self-clearing start request
		logic       start;
	} ctrl_word_t;

	// Write data seen either as a plain word or as word 0 fields
	typedef union packed {
		logic [csr_data_w-1:0] raw;
		ctrl_word_t            ctrl;
	} csr_word_u;

	// One register write, valid for a single cycle
	typedef struct packed {
		logic                   valid;
		logic [csr_index_w-1:0] index;
		csr_word_u              data;
		logic [csr_strb_w-1:0]  strb;
	} reg_write_t;

	// Configuration seen by the accelerator
	typedef struct packed {
		logic [7:0]            kernel_size;
		logic [7:0]            stride;
		logic [7:0]            padding;
		logic                  has_bias;
		logic                  has_relu;
		logic                  conv_mode;
		logic [csr_data_w-1:0] kernel_base;
		logic [csr_data_w-1:0] feature_base;
		logic [csr_data_w-1:0] feature_width;
		logic [csr_data_w-1:0] feature_height;
		logic [csr_data_w-1:0] feature_chin;
		logic [csr_data_w-1:0] feature_chout;
		logic [csr_data_w-1:0] output_base;
		logic [csr_data_w-1:0] output_width;
		logic [csr_data_w-1:0] output_height;
	} conv_cfg_t;

	// Status flags from the accelerator
	typedef struct packed {
		logic running;
		logic compute_done;
		logic exception;
	} conv_status_t;

endpackage

// File: hdl/csr_write_channel.sv
`timescale 1ns/1ps

module csr_write_channel #(
	parameter int addr_width = 6
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// AW channel
	input  logic [addr_width-1:0]                awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	// W channel
	input  logic [conv_csr_pkg::csr_data_w-1:0]  wdata,
	input  logic [conv_csr_pkg::csr_strb_w-1:0]  wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	// B channel
	output logic                                 bvalid,
	input  logic                                 bready,
	// Write request into the register block
	output conv_csr_pkg::reg_write_t             wr
);

	import conv_csr_pkg::*;

	// Idle only exists for the cycle after reset release
	typedef enum logic [1:0] {
		wr_idle,
		wr_addr,
		wr_data,
		wr_resp
	} wr_state_t;

	wr_state_t              state_q;
	wr_state_t              state_d;
	logic [csr_index_w-1:0] index_q;
	logic                   aw_hs;
	logic                   w_hs;
	logic                   b_hs;

	// --------------------
	// Handshakes
	// --------------------

	// Ready and valid come straight from the state register
	assign awready = (state_q == wr_addr);
	assign wready  = (state_q == wr_data);
	assign bvalid  = (state_q == wr_resp);

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;
	assign b_hs  = bvalid & bready;

	// --------------------
	// State machine
	// --------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			wr_idle: state_d = wr_addr;
			// Address first, data is not taken before AW
			wr_addr: if (aw_hs) state_d = wr_data;
			wr_data: if (w_hs) state_d = wr_resp;
			// Next address waits for the master to take the response
			wr_resp: if (b_hs) state_d = wr_addr;
			default: state_d = wr_idle;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			state_q <= wr_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// Word index held from AW until the data arrives
	// Upper address bits above the index alias onto the same words
	always_ff @(posedge S_AXI_ACLK) begin
		if (aw_hs) begin
			index_q <= awaddr[addr_lsb +: csr_index_w];
		end
	end

	// --------------------
	// Register write
	// --------------------

	// One-cycle write, issued in the W handshake cycle
	assign wr.valid    = w_hs;
	assign wr.index    = index_q;
	assign wr.data.raw = wdata;
	assign wr.strb     = wstrb;

endmodule

// File: hdl/csr_read_channel.sv
`timescale 1ns/1ps

module csr_read_channel #(
	parameter int addr_width = 6
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// AR channel
	input  logic [addr_width-1:0]                araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	// R channel
	output logic [conv_csr_pkg::csr_data_w-1:0]  rdata,
	output logic                                 rvalid,
	input  logic                                 rready,
	// Lookup into the register block
	output logic [conv_csr_pkg::csr_index_w-1:0] rd_index,
	input  logic [conv_csr_pkg::csr_data_w-1:0]  rd_word
);

	import conv_csr_pkg::*;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_data
	} rd_state_t;

	rd_state_t state_q;
	logic      ar_hs;
	logic      r_hs;

	assign arready = (state_q == rd_addr);
	assign rvalid  = (state_q == rd_data);

	assign ar_hs = arvalid & arready;
	assign r_hs  = rvalid & rready;

	// Index goes out combinationally, the word comes back in the same cycle
	assign rd_index = araddr[addr_lsb +: csr_index_w];

	// --------------------
	// State machine
	// --------------------

	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			state_q <= rd_idle;
		end else begin
			case (state_q)
				rd_idle: state_q <= rd_addr;
				rd_addr: if (ar_hs) state_q <= rd_data;
				rd_data: if (r_hs) state_q <= rd_addr;
				default: state_q <= rd_idle;
			endcase
		end
	end

	// Snapshot at AR, held steady while rready is low
	always_ff @(posedge S_AXI_ACLK) begin
		if (ar_hs) begin
			rdata <= rd_word;
		end
	end

endmodule

// File: hdl/conv_csr_regs.sv
`timescale 1ns/1ps

module conv_csr_regs (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// One-cycle write from the write channel
	input  conv_csr_pkg::reg_write_t             wr,
	// Combinational read port
	input  logic [conv_csr_pkg::csr_index_w-1:0] rd_index,
	output logic [conv_csr_pkg::csr_data_w-1:0]  rd_word,
	// Accelerator side
	output conv_csr_pkg::conv_cfg_t              cfg,
	output logic                                 start,
	input  conv_csr_pkg::conv_status_t           status
);

	import conv_csr_pkg::*;

	conv_cfg_t    cfg_q;
	conv_status_t status_q;
	logic         start_q;
	logic         wr_mapped;
	logic         wr_ctrl;
	ctrl_word_t   rd_ctrl;

	// Byte lane merge for words 1 to 9
	function automatic logic [csr_data_w-1:0] merge_bytes(
		input logic [csr_data_w-1:0] old_word,
		input logic [csr_data_w-1:0] new_word,
		input logic [csr_strb_w-1:0] strb
	);
		logic [csr_data_w-1:0] merged;
		merged = old_word;
		for (int b = 0; b < csr_strb_w; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// Indices 10 to 15 are dropped here
	assign wr_mapped = wr.valid && (wr.index < csr_num_words);
	assign wr_ctrl   = wr_mapped && (wr.index == idx_ctrl);

	// --------------------
	// Register storage
	// --------------------

	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			cfg_q <= '0;
		end else if (wr_mapped) begin
			case (wr.index)
				// Word 0 takes whole fields, strobes ignored
				idx_ctrl: begin
					cfg_q.kernel_size <= wr.data.ctrl.kernel_size;
					cfg_q.stride      <= wr.data.ctrl.stride;
					cfg_q.padding     <= wr.data.ctrl.padding;
					cfg_q.has_bias    <= wr.data.ctrl.has_bias;
					cfg_q.has_relu    <= wr.data.ctrl.has_relu;
					cfg_q.conv_mode   <= wr.data.ctrl.conv_mode;
				end
				idx_kernel_base:
					cfg_q.kernel_base <= merge_bytes(cfg_q.kernel_base, wr.data.raw, wr.strb);
				idx_feature_base:
					cfg_q.feature_base <= merge_bytes(cfg_q.feature_base, wr.data.raw, wr.strb);
				idx_feature_width:
					cfg_q.feature_width <= merge_bytes(cfg_q.feature_width, wr.data.raw, wr.strb);
				idx_feature_height:
					cfg_q.feature_height <= merge_bytes(cfg_q.feature_height, wr.data.raw, wr.strb);
				idx_feature_chin:
					cfg_q.feature_chin <= merge_bytes(cfg_q.feature_chin, wr.data.raw, wr.strb);
				idx_feature_chout:
					cfg_q.feature_chout <= merge_bytes(cfg_q.feature_chout, wr.data.raw, wr.strb);
				idx_output_base:
					cfg_q.output_base <= merge_bytes(cfg_q.output_base, wr.data.raw, wr.strb);
				idx_output_width:
					cfg_q.output_width <= merge_bytes(cfg_q.output_width, wr.data.raw, wr.strb);
				idx_output_height:
					cfg_q.output_height <= merge_bytes(cfg_q.output_height, wr.data.raw, wr.strb);
				default: ;
			endcase
		end
	end

	// --------------------
	// Start and status
	// --------------------

	// Start lasts one cycle, cleared unless word 0 is written again
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			start_q <= 1'b0;
		end else begin
			start_q <= wr_ctrl && wr.data.ctrl.start;
		end
	end

	// Status sampled every cycle
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			status_q <= '0;
		end else begin
			status_q <= status;
		end
	end

	assign cfg   = cfg_q;
	assign start = start_q;

	// --------------------
	// Read mux
	// --------------------

	// Word 0 readback, start and bit 4 always read zero
	always_comb begin
		rd_ctrl              = '0;
		rd_ctrl.kernel_size  = cfg_q.kernel_size;
		rd_ctrl.stride       = cfg_q.stride;
		rd_ctrl.padding      = cfg_q.padding;
		rd_ctrl.has_bias     = cfg_q.has_bias;
		rd_ctrl.has_relu     = cfg_q.has_relu;
		rd_ctrl.conv_mode    = cfg_q.conv_mode;
		rd_ctrl.running      = status_q.running;
		rd_ctrl.compute_done = status_q.compute_done;
		rd_ctrl.exception    = status_q.exception;
	end

	always_comb begin
		case (rd_index)
			idx_ctrl:           rd_word = rd_ctrl;
			idx_kernel_base:    rd_word = cfg_q.kernel_base;
			idx_feature_base:   rd_word = cfg_q.feature_base;
			idx_feature_width:  rd_word = cfg_q.feature_width;
			idx_feature_height: rd_word = cfg_q.feature_height;
			idx_feature_chin:   rd_word = cfg_q.feature_chin;
			idx_feature_chout:  rd_word = cfg_q.feature_chout;
			idx_output_base:    rd_word = cfg_q.output_base;
			idx_output_width:   rd_word = cfg_q.output_width;
			idx_output_height:  rd_word = cfg_q.output_height;
			// Unmapped slots
			default:            rd_word = '0;
		endcase
	end

endmodule

// File: hdl/axi_csr_top.sv
`timescale 1ns/1ps

module axi_csr_top #(
	parameter int addr_width = 6
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// AW channel
	input  logic [addr_width-1:0]                s_axi_awaddr,
	input  logic                                 s_axi_awvalid,
	output logic                                 s_axi_awready,
	// W channel
	input  logic [conv_csr_pkg::csr_data_w-1:0]  s_axi_wdata,
	input  logic [conv_csr_pkg::csr_strb_w-1:0]  s_axi_wstrb,
	input  logic                                 s_axi_wvalid,
	output logic                                 s_axi_wready,
	// B channel, response code is tied off outside
	output logic                                 s_axi_bvalid,
	input  logic                                 s_axi_bready,
	// AR channel
	input  logic [addr_width-1:0]                s_axi_araddr,
	input  logic                                 s_axi_arvalid,
	output logic                                 s_axi_arready,
	// R channel
	output logic [conv_csr_pkg::csr_data_w-1:0]  s_axi_rdata,
	output logic                                 s_axi_rvalid,
	input  logic                                 s_axi_rready,
	// Accelerator side
	output conv_csr_pkg::conv_cfg_t              cfg,
	output logic                                 start,
	input  conv_csr_pkg::conv_status_t           status
);

	import conv_csr_pkg::*;

	// Write request and read lookup between channels and registers
	reg_write_t             wr;
	logic [csr_index_w-1:0] rd_index;
	logic [csr_data_w-1:0]  rd_word;

	// --------------------
	// Write channel
	// --------------------

	csr_write_channel #(
		.addr_width (addr_width)
	) u_write_channel (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.awaddr        (s_axi_awaddr),
		.awvalid       (s_axi_awvalid),
		.awready       (s_axi_awready),
		.wdata         (s_axi_wdata),
		.wstrb         (s_axi_wstrb),
		.wvalid        (s_axi_wvalid),
		.wready        (s_axi_wready),
		.bvalid        (s_axi_bvalid),
		.bready        (s_axi_bready),
		.wr            (wr)
	);

	// --------------------
	// Read channel
	// --------------------

	csr_read_channel #(
		.addr_width (addr_width)
	) u_read_channel (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.araddr        (s_axi_araddr),
		.arvalid       (s_axi_arvalid),
		.arready       (s_axi_arready),
		.rdata         (s_axi_rdata),
		.rvalid        (s_axi_rvalid),
		.rready        (s_axi_rready),
		.rd_index      (rd_index),
		.rd_word       (rd_word)
	);

	// Register block, always accepts the write
	conv_csr_regs u_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr            (wr),
		.rd_index      (rd_index),
		.rd_word       (rd_word),
		.cfg           (cfg),
		.start         (start),
		.status        (status)
	);

endmodule

// File: testbench/axi_csr_properties.sv
`timescale 1ns/1ps

module axi_csr_properties (
	input logic                                S_AXI_ACLK,
	input logic                                S_AXI_ARESETN,
	input logic                                s_axi_awvalid,
	input logic                                s_axi_awready,
	input logic                                s_axi_wready,
	input logic                                s_axi_bvalid,
	input logic                                s_axi_bready,
	input logic                                s_axi_rvalid,
	input logic                                s_axi_rready,
	input logic [conv_csr_pkg::csr_data_w-1:0] s_axi_rdata,
	input logic                                start
);

	// --------------------
	// Channel handshakes
	// --------------------

	// Response stays up until the master takes it
	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
		else $error("bvalid dropped before bready");

	// Read data frozen while the master stalls
	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
		else $error("rvalid or rdata changed before rready");

	// Address phase closes and data phase opens right after AW
	aw_w_exclusive: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_awvalid && s_axi_awready |=> s_axi_wready && !s_axi_awready)
		else $error("wready not alone in the cycle after the AW handshake");

	// Single-cycle start
	start_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		start |=> !start)
		else $error("start held for two cycles");

endmodule

bind axi_csr_top axi_csr_properties u_properties (
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.s_axi_awvalid (s_axi_awvalid),
	.s_axi_awready (s_axi_awready),
	.s_axi_wready  (s_axi_wready),
	.s_axi_bvalid  (s_axi_bvalid),
	.s_axi_bready  (s_axi_bready),
	.s_axi_rvalid  (s_axi_rvalid),
	.s_axi_rready  (s_axi_rready),
	.s_axi_rdata   (s_axi_rdata),
	.start         (start)
);

// File: testbench/tb_axi_csr_top.sv
`timescale 1ns/1ps

module tb_axi_csr_top;

	import conv_csr_pkg::*;

	localparam int          addr_width   = 6;
	localparam time         clk_period   = 10ns;
	localparam int          reset_cycles = 16;
	localparam logic [31:0] seed         = 32'h8d53;
	// About 80 transactions of up to 15 cycles each, plus reset and margin
	localparam int          timeout_cycles = 2000;

	logic                  S_AXI_ACLK;
	logic                  S_AXI_ARESETN;
	logic [addr_width-1:0] s_axi_awaddr, s_axi_araddr;
	logic                  s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
	logic [csr_data_w-1:0] s_axi_wdata, s_axi_rdata;
	logic [csr_strb_w-1:0] s_axi_wstrb;
	logic                  s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
	logic                  s_axi_rvalid, s_axi_rready;
	conv_cfg_t             cfg;
	logic                  start;
	conv_status_t          status;

	// Reference register words, word 0 keeps only its stored fields
	logic [csr_data_w-1:0] model [csr_num_words];
	logic [csr_data_w-1:0] exp_rdata;
	string                 exp_name;
	int unsigned           cycle_count = 0;
	int unsigned           start_count = 0;
	int unsigned           reads_issued = 0;
	int unsigned           reads_checked = 0;

	axi_csr_top #(
		.addr_width (addr_width)
	) u_axi_csr_top (.*);

	always #(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;

	// Stored word after a write, from the register map rules
	function automatic logic [csr_data_w-1:0] next_word(input logic [csr_data_w-1:0] prev,
		input logic [csr_data_w-1:0] data, input logic [csr_strb_w-1:0] strb, input int index);
		logic [csr_data_w-1:0] result;
		result = prev;
		if (index == 0) begin
			// Fields at bits 31:5, strobes do not apply
			result = data & 32'hffff_ffe0;
		end else if (index < csr_num_words) begin
			for (int b = 0; b < csr_strb_w; b++) begin
				if (strb[b]) result[8*b +: 8] = data[8*b +: 8];
			end
		end
		return result;
	endfunction

	// Expected readback, word 0 carries the held status at bits 3:1
	function automatic logic [csr_data_w-1:0] readback_value(input int index);
		if (index == 0) begin
			return model[0] | {28'd0, status, 1'b0};
		end
		if (index < csr_num_words) begin
			return model[index];
		end
		return '0;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string name);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic verify_cfg();
		check_value(cfg.kernel_size, model[0][31:24], "cfg.kernel_size");
		check_value(cfg.stride, model[0][23:16], "cfg.stride");
		check_value(cfg.padding, model[0][15:8], "cfg.padding");
		check_value(cfg.has_bias, model[0][7], "cfg.has_bias");
		check_value(cfg.has_relu, model[0][6], "cfg.has_relu");
		check_value(cfg.conv_mode, model[0][5], "cfg.conv_mode");
		check_value(cfg.kernel_base, model[1], "cfg.kernel_base");
		check_value(cfg.feature_base, model[2], "cfg.feature_base");
		check_value(cfg.feature_width, model[3], "cfg.feature_width");
		check_value(cfg.feature_height, model[4], "cfg.feature_height");
		check_value(cfg.feature_chin, model[5], "cfg.feature_chin");
		check_value(cfg.feature_chout, model[6], "cfg.feature_chout");
		check_value(cfg.output_base, model[7], "cfg.output_base");
		check_value(cfg.output_width, model[8], "cfg.output_width");
		check_value(cfg.output_height, model[9], "cfg.output_height");
	endtask

	// --------------------
	// Bus master tasks
	// --------------------

	// Ready flags come from state registers, so they are sampled mid-cycle
	task automatic write_word(input int index, input logic [csr_data_w-1:0] data,
		input logic [csr_strb_w-1:0] strb);
		int bdelay;
		bdelay = $urandom_range(0, 3);
		@(negedge S_AXI_ACLK);
		s_axi_awaddr  = addr_width'(index << addr_lsb);
		s_axi_awvalid = 1'b1;
		while (!s_axi_awready) @(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = data;
		s_axi_wstrb   = strb;
		s_axi_wvalid  = 1'b1;
		while (!s_axi_wready) @(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		s_axi_wvalid = 1'b0;
		while (!s_axi_bvalid) @(negedge S_AXI_ACLK);
		repeat (bdelay) @(negedge S_AXI_ACLK);
		s_axi_bready = 1'b1;
		@(negedge S_AXI_ACLK);
		s_axi_bready = 1'b0;
		if (index < csr_num_words) model[index] = next_word(model[index], data, strb, index);
	endtask

	// Hold is the number of cycles rready stays low once rvalid is up
	task automatic read_word(input int index, input int hold);
		@(negedge S_AXI_ACLK);
		s_axi_araddr  = addr_width'(index << addr_lsb);
		s_axi_arvalid = 1'b1;
		exp_rdata     = readback_value(index);
		exp_name      = $sformatf("s_axi_rdata[word %0d]", index);
		reads_issued++;
		while (!s_axi_arready) @(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid) @(negedge S_AXI_ACLK);
		repeat (hold) @(negedge S_AXI_ACLK);
		s_axi_rready = 1'b1;
		@(negedge S_AXI_ACLK);
		s_axi_rready = 1'b0;
	endtask

	// Compare every R handshake against the expected word
	always @(posedge S_AXI_ACLK) begin
		if (s_axi_rvalid && s_axi_rready) begin
			check_value(s_axi_rdata, exp_rdata, exp_name);
			reads_checked++;
		end
	end

	// Start pulses and the run limit
	always @(posedge S_AXI_ACLK) begin
		cycle_count++;
		if (start) start_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Some tests failed");
			$fatal(1, "Timeout: test sequence still running after %0d cycles", timeout_cycles);
		end
	end

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		int unsigned           starts_before;
		int unsigned           starts_expected;
		logic [csr_data_w-1:0] data;
		logic [2:0]            patterns [5];
		void'($urandom(seed));
		patterns        = '{3'b001, 3'b010, 3'b100, 3'b111, 3'b101};
		starts_expected = 0;
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		status        = '0;
		for (int i = 0; i < csr_num_words; i++) model[i] = '0;
		repeat (reset_cycles) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		// Reset values
		verify_cfg();
		check_value(start, 1'b0, "start");
		check_value(s_axi_bvalid, 1'b0, "s_axi_bvalid");
		check_value(s_axi_rvalid, 1'b0, "s_axi_rvalid");
		for (int i = 0; i < csr_num_words; i++) read_word(i, 0);

		// Full then partial strobe writes to words 1 to 9
		for (int i = 1; i < csr_num_words; i++) begin
			write_word(i, $urandom(), 4'hf);
			verify_cfg();
			read_word(i, $urandom_range(0, 3));
		end
		for (int i = 1; i < csr_num_words; i++) begin
			write_word(i, $urandom(), $urandom_range(1, 14));
			verify_cfg();
			read_word(i, $urandom_range(0, 3));
		end

		// Control word, start set on every other write
		for (int n = 0; n < 6; n++) begin
			data          = $urandom();
			data[0]       = n[0];
			starts_before = start_count;
			starts_expected += n[0];
			write_word(0, data, $urandom_range(0, 15));
			verify_cfg();
			check_value(start_count - starts_before, n[0], "start pulse count");
			read_word(0, $urandom_range(0, 3));
		end
		foreach (patterns[p]) begin
			@(negedge S_AXI_ACLK);
			status = patterns[p];
			repeat (2) @(negedge S_AXI_ACLK);
			read_word(0, $urandom_range(0, 3));
		end
		status = '0;

		// Unmapped slots, then a read under back-pressure
		for (int i = csr_num_words; i < 16; i++) begin
			write_word(i, $urandom(), 4'hf);
			verify_cfg();
			read_word(i, $urandom_range(0, 3));
		end
		read_word(3, 6);
		// Only word 0 writes with bit 0 set may have pulsed start
		check_value(start_count, starts_expected, "start pulse total");
		check_value(reads_checked, reads_issued, "reads_checked");

		$display("All tests passed");
		$finish;
	end

endmodule

// File: axi_csr_top.f
hdl/conv_csr_pkg.sv
hdl/csr_write_channel.sv
hdl/csr_read_channel.sv
hdl/conv_csr_regs.sv
hdl/axi_csr_top.sv
testbench/axi_csr_properties.sv
testbench/tb_axi_csr_top.sv

// File: Bender.yml
package:
  name: axi_csr_top

sources:
  - files:
      - hdl/conv_csr_pkg.sv
      - hdl/csr_write_channel.sv
      - hdl/csr_read_channel.sv
      - hdl/conv_csr_regs.sv
      - hdl/axi_csr_top.sv
  - target: test
    files:
      - testbench/axi_csr_properties.sv
      - testbench/tb_axi_csr_top.sv
